/* sim.f */
+incdir+.
ooo_issue_pkg.sv
ooo_commit_pkg.sv
ooo_bus_if.sv
rename_map.sv
prf.sv
rs.sv
fu_cdb.sv
rob.sv
ooo.sv
ooo_checker.sv
ooo_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := ooo_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/1ps

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: all build run lint clean

/* ooo_tb.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_tb;

    import ooo_issue_pkg::*;

    localparam int TIMEOUT = 200;

    logic              clock = 1'b0;
    logic              reset;
    logic              dispatch_valid;
    alu_op_e           dispatch_op;
    logic [`ARN_W-1:0] dest_arn;
    logic [`ARN_W-1:0] src1_arn;
    logic [`ARN_W-1:0] src2_arn;
    logic [`XLEN-1:0]  imm;
    logic              stall;
    logic              commit_valid;
    logic [`ARN_W-1:0] commit_arn;
    logic [`XLEN-1:0]  commit_value;
    logic              commit_wr_en;

    // in-order reference state
    logic [`XLEN-1:0]  arch_regs [`ARCH_REG_SZ];
    logic [`ARN_W-1:0] exp_arn_q [$];
    logic [`XLEN-1:0]  exp_val_q [$];
    logic              stall_seen;
    integer            seed;

    ooo ooo_i (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dest_arn(dest_arn), .src1_arn(src1_arn), .src2_arn(src2_arn), .imm(imm),
        .stall(stall),
        .commit_valid(commit_valid), .commit_arn(commit_arn),
        .commit_value(commit_value), .commit_wr_en(commit_wr_en)
    );

    always #5 clock = ~clock;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [`XLEN-1:0] got,
                                input logic [`XLEN-1:0] expected);
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        abort_run();
    endtask

    function automatic logic [`XLEN-1:0] golden_result(input alu_op_e op,
                                                       input logic [`XLEN-1:0] a,
                                                       input logic [`XLEN-1:0] b,
                                                       input logic [`XLEN-1:0] value);
        logic [`XLEN-1:0] res;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
            OP_LI:   res = value;
            // multiply keeps the low XLEN bits
            default: res = a * b;
        endcase
        return res;
    endfunction

    // returns on the rising edge that takes the instruction
    task automatic dispatch(input alu_op_e op, input logic [`ARN_W-1:0] d,
                            input logic [`ARN_W-1:0] s1, input logic [`ARN_W-1:0] s2,
                            input logic [`XLEN-1:0] value);
        int               waited;
        logic [`XLEN-1:0] result;
        dispatch_valid <= 1'b1;
        dispatch_op    <= op;
        dest_arn       <= d;
        src1_arn       <= s1;
        src2_arn       <= s2;
        imm            <= value;
        waited = 0;
        @(negedge clock);
        while (stall) begin
            stall_seen = 1'b1;
            waited++;
            assert (waited < TIMEOUT) else report_error("dispatch stalled too long");
            @(negedge clock);
        end
        result = golden_result(op, arch_regs[s1], arch_regs[s2], value);
        if (d != '0) begin
            arch_regs[d] = result;
        end
        exp_arn_q.push_back(d);
        exp_val_q.push_back(result);
        @(posedge clock);
    endtask

    task automatic idle(input int cycles);
        dispatch_valid <= 1'b0;
        repeat (cycles) @(posedge clock);
    endtask

    task automatic wait_drain();
        int waited;
        dispatch_valid <= 1'b0;
        waited = 0;
        while (exp_arn_q.size() != 0) begin
            waited++;
            assert (waited < TIMEOUT) else report_error("commits did not drain in time");
            @(posedge clock);
        end
    endtask

    task automatic check_commit();
        logic [`ARN_W-1:0] arn;
        logic [`XLEN-1:0]  value;
        assert (exp_arn_q.size() != 0) else report_error("commit with nothing outstanding");
        arn   = exp_arn_q.pop_front();
        value = exp_val_q.pop_front();
        assert (commit_arn == arn)
            else report_value("commit_arn", `XLEN'(commit_arn), `XLEN'(arn));
        assert (commit_wr_en == (arn != '0))
            else report_value("commit_wr_en", `XLEN'(commit_wr_en), `XLEN'(arn != '0));
        if (arn != '0) begin
            assert (commit_value == value)
                else report_value("commit_value", commit_value, value);
        end
    endtask

    // commit monitor
    always @(negedge clock) begin
        if (!reset) begin
            assert (!$isunknown(commit_valid)) else report_error("commit_valid is unknown");
            if (commit_valid) begin
                check_commit();
            end
        end
    end

    initial begin
        logic [31:0] r;
        seed           = 35;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dest_arn       = '0;
        src1_arn       = '0;
        src2_arn       = '0;
        imm            = '0;
        stall_seen     = 1'b0;
        for (int i = 0; i < `ARCH_REG_SZ; i++) begin
            arch_regs[i] = '0;
        end
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!stall) else report_value("stall", `XLEN'(stall), '0);
        assert (!commit_valid) else report_value("commit_valid", `XLEN'(commit_valid), '0);
        @(posedge clock);

        // r7 is never written here
        dispatch(OP_ADD, 1, 2, 3, '0);
        dispatch(OP_OR, 2, 4, 7, '0);
        for (int i = 1; i < 7; i++) begin
            dispatch(OP_LI, 3'(i), 0, 0, `XLEN'(i * 16'h0101));
        end
        for (int i = 0; i < 8; i++) begin
            dispatch(OP_ADD, 3'((i + 1) % 7), 3'(i), 3'(7 - i), '0);
        end
        wait_drain();

        // back-to-back raw chain
        dispatch(OP_LI, 1, 0, 0, 16'h1234);
        dispatch(OP_ADD, 2, 1, 1, '0);
        dispatch(OP_SUB, 3, 2, 1, '0);
        dispatch(OP_XOR, 1, 3, 2, '0);
        dispatch(OP_AND, 2, 1, 3, '0);
        dispatch(OP_OR, 3, 2, 1, '0);
        dispatch(OP_SLT, 4, 1, 3, '0);
        dispatch(OP_ADD, 4, 4, 4, '0);
        wait_drain();

        // alu ops finish ahead of the older multiply
        dispatch(OP_LI, 5, 0, 0, 16'h00ff);
        dispatch(OP_LI, 6, 0, 0, 16'h0102);
        dispatch(OP_MUL, 7, 5, 6, '0);
        dispatch(OP_ADD, 1, 5, 6, '0);
        dispatch(OP_XOR, 2, 5, 6, '0);
        dispatch(OP_SUB, 3, 6, 5, '0);
        wait_drain();

        stall_seen = 1'b0;
        dispatch(OP_LI, 1, 0, 0, 16'h0003);
        dispatch(OP_LI, 2, 0, 0, 16'h0007);
        for (int i = 0; i < 16; i++) begin
            dispatch(OP_MUL, 3'(1 + i % 2), 1, 2, '0);
        end
        wait_drain();
        assert (stall_seen) else report_error("stall never rose during the multiply burst");

        // r0 writes are dropped
        dispatch(OP_LI, 0, 0, 0, 16'h55aa);
        dispatch(OP_ADD, 0, 1, 2, '0);
        dispatch(OP_MUL, 0, 1, 2, '0);
        dispatch(OP_ADD, 3, 0, 0, '0);
        dispatch(OP_OR, 4, 0, 1, '0);
        wait_drain();

        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            dispatch(alu_op_e'(r[2:0]), r[5:3], r[8:6], r[11:9], r[31:16]);
            if (r[15:12] == 4'd0) begin
                idle(2);
            end
        end
        wait_drain();

        // a duplicated commit after the drain hits the empty queue
        idle(2 * `ROB_SZ);
        $display("sim passed");
        $finish;
    end

endmodule

/* ooo_checker.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_checker (
    input logic              clock,
    input logic              reset,
    input logic              stall,
    input logic              commit_valid,
    input logic [`ARN_W-1:0] commit_arn,
    input logic              commit_wr_en
);

    // outputs come out of reset quiet
    quiet_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (!stall && !commit_valid))
        else $error("stall or commit_valid high in the cycle after reset");

    no_r0_write: assert property (
        @(posedge clock) disable iff (reset) commit_wr_en |-> (commit_arn != '0))
        else $error("commit_wr_en high while commit_arn is register 0");

    valid_known: assert property (
        @(posedge clock) disable iff (reset) !$isunknown(commit_valid))
        else $error("commit_valid is unknown");

endmodule

bind ooo ooo_checker ooo_checker_i (
    .clock(clock),
    .reset(reset),
    .stall(stall),
    .commit_valid(commit_valid),
    .commit_arn(commit_arn),
    .commit_wr_en(commit_wr_en)
);

/* ooo.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  ooo_issue_pkg::alu_op_e dispatch_op,
    input  logic [`ARN_W-1:0]      dest_arn,
    input  logic [`ARN_W-1:0]      src1_arn,
    input  logic [`ARN_W-1:0]      src2_arn,
    input  logic [`XLEN-1:0]       imm,
    output logic                   stall,
    output logic                   commit_valid,
    output logic [`ARN_W-1:0]      commit_arn,
    output logic [`XLEN-1:0]       commit_value,
    output logic                   commit_wr_en
);

    import ooo_issue_pkg::*;
    import ooo_commit_pkg::*;

    cdb_bus    cdb ();
    commit_bus commit ();

    logic               accept;
    logic               free_empty;
    logic               rs_full;
    logic               rob_full;
    logic [`PRN_W-1:0]  src1_prn;
    logic [`PRN_W-1:0]  src2_prn;
    logic [`PRN_W-1:0]  new_prn;
    logic [`PRN_W-1:0]  old_prn;
    logic [`XLEN-1:0]   prf_value1;
    logic [`XLEN-1:0]   prf_value2;
    logic               prf_ready1;
    logic               prf_ready2;
    logic               hit1;
    logic               hit2;
    logic [`ROBN_W-1:0] tail_robn;
    logic               issue_valid;
    logic               alu_avail;
    rs_entry_t          rs_entry;
    rs_entry_t          issue_entry;
    rob_entry_t         rob_entry;

    // value if known, else the same-cycle cdb result, else the tag
    function automatic operand_u form_operand(input logic             ready,
                                              input logic [`XLEN-1:0] value,
                                              input logic [`PRN_W-1:0] prn,
                                              input logic             hit,
                                              input logic [`XLEN-1:0] bypass);
        operand_u op;
        op.tag.pad = '0;
        op.tag.prn = prn;
        if (ready) begin
            op.value = value;
        end else if (hit) begin
            op.value = bypass;
        end
        return op;
    endfunction

    assign stall  = free_empty || rs_full || rob_full;
    assign accept = dispatch_valid && !stall;

    assign hit1 = cdb.valid && (cdb.dest_prn == src1_prn);
    assign hit2 = cdb.valid && (cdb.dest_prn == src2_prn);

    always_comb begin
        rs_entry.valid     = 1'b1;
        rs_entry.op        = dispatch_op;
        rs_entry.dest_prn  = new_prn;
        rs_entry.robn      = tail_robn;
        rs_entry.op1_ready = prf_ready1 || hit1;
        rs_entry.op2_ready = prf_ready2 || hit2;
        rs_entry.op1 = form_operand(prf_ready1, prf_value1, src1_prn, hit1, cdb.value);
        rs_entry.op2 = form_operand(prf_ready2, prf_value2, src2_prn, hit2, cdb.value);
        // li carries its immediate as a ready operand
        if (dispatch_op == OP_LI) begin
            rs_entry.op1_ready = 1'b1;
            rs_entry.op2_ready = 1'b1;
            rs_entry.op1.value = imm;
            rs_entry.op2.value = imm;
        end
        rob_entry = '{dest_arn: dest_arn, dest_prn: new_prn, old_prn: old_prn, done: 1'b0};
    end

    rename_map rename_map_inst (
        .clock(clock), .reset(reset), .rename_en(accept),
        .src1_arn(src1_arn), .src2_arn(src2_arn), .dest_arn(dest_arn),
        .src1_prn(src1_prn), .src2_prn(src2_prn), .dest_prn(new_prn), .old_prn(old_prn),
        .free_empty(free_empty), .commit(commit)
    );

    prf prf_inst (
        .clock(clock), .reset(reset),
        .read_prn1(src1_prn), .read_prn2(src2_prn),
        .read_value1(prf_value1), .read_value2(prf_value2),
        .read_ready1(prf_ready1), .read_ready2(prf_ready2),
        .alloc_en(accept && (dest_arn != '0)), .alloc_prn(new_prn),
        .cdb(cdb), .commit(commit), .commit_value(commit_value)
    );

    rs rs_inst (
        .clock(clock), .reset(reset), .insert_en(accept), .insert_entry(rs_entry),
        .cdb(cdb), .alu_avail(alu_avail),
        .issue_valid(issue_valid), .issue_entry(issue_entry), .full(rs_full)
    );

    fu_cdb fu_cdb_inst (
        .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue_entry(issue_entry),
        .alu_avail(alu_avail), .cdb(cdb)
    );

    rob rob_inst (
        .clock(clock), .reset(reset), .alloc_en(accept), .alloc_entry(rob_entry),
        .tail_robn(tail_robn), .full(rob_full), .cdb(cdb), .commit(commit)
    );

    // commit output, one cycle behind the rob head
    always_ff @(posedge clock) begin
        commit_arn <= commit.dest_arn;
        if (reset) begin
            commit_valid <= 1'b0;
            commit_wr_en <= 1'b0;
        end else begin
            commit_valid <= commit.valid;
            commit_wr_en <= commit.valid && (commit.dest_arn != '0);
        end
    end

endmodule

/* rob.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rob (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        alloc_en,
    input  ooo_commit_pkg::rob_entry_t  alloc_entry,
    output logic [`ROBN_W-1:0]          tail_robn,
    output logic                        full,
    cdb_bus.sink                        cdb,
    commit_bus.source                   commit
);

    import ooo_commit_pkg::*;

    rob_entry_t         entries [`ROB_SZ];
    logic [`ROBN_W-1:0] head;
    logic [`ROBN_W-1:0] tail;
    logic [`ROBN_W:0]   count;
    logic               retire;

    assign retire    = (count != '0) && entries[head].done;
    assign full      = (count == `ROB_SZ);
    assign tail_robn = tail;

    assign commit.valid    = retire;
    assign commit.dest_arn = entries[head].dest_arn;
    assign commit.dest_prn = entries[head].dest_prn;
    assign commit.old_prn  = entries[head].old_prn;

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                entries[tail] <= alloc_entry;
                tail          <= tail + 1'b1;
            end
            // completion by robn
            if (cdb.valid) begin
                entries[cdb.robn].done <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (`ROBN_W+1)'(alloc_en) - (`ROBN_W+1)'(retire);
        end
    end

endmodule

/* fu_cdb.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module fu_cdb (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  ooo_issue_pkg::rs_entry_t issue_entry,
    output logic                     alu_avail,
    cdb_bus.source                   cdb
);

    import ooo_issue_pkg::*;
    import ooo_commit_pkg::*;

    cdb_t             alu_q;
    cdb_t             mul_q [`MULT_STAGES];
    cdb_t             cdb_out;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] product;
    logic             is_mul;

    assign a       = issue_entry.op1.value;
    assign b       = issue_entry.op2.value;
    assign product = a * b;
    assign is_mul  = (issue_entry.op == OP_MUL);

    always_comb begin
        case (issue_entry.op)
            OP_ADD:  alu_result = a + b;
            OP_SUB:  alu_result = a - b;
            OP_AND:  alu_result = a & b;
            OP_OR:   alu_result = a | b;
            OP_XOR:  alu_result = a ^ b;
            OP_SLT:  alu_result = `XLEN'($signed(a) < $signed(b));
            OP_LI:   alu_result = a;
            default: alu_result = '0;
        endcase
    end

    // a product lands on the cdb next cycle, keep the alu off it
    assign alu_avail = !mul_q[`MULT_STAGES-2].valid;

    always_ff @(posedge clock) begin
        alu_q.dest_prn    <= issue_entry.dest_prn;
        alu_q.robn        <= issue_entry.robn;
        alu_q.value       <= alu_result;
        mul_q[0].dest_prn <= issue_entry.dest_prn;
        mul_q[0].robn     <= issue_entry.robn;
        mul_q[0].value    <= product;
        for (int i = 1; i < `MULT_STAGES; i++) begin
            mul_q[i].dest_prn <= mul_q[i-1].dest_prn;
            mul_q[i].robn     <= mul_q[i-1].robn;
            mul_q[i].value    <= mul_q[i-1].value;
        end
        if (reset) begin
            alu_q.valid <= 1'b0;
            for (int i = 0; i < `MULT_STAGES; i++) begin
                mul_q[i].valid <= 1'b0;
            end
        end else begin
            alu_q.valid    <= issue_valid && !is_mul;
            mul_q[0].valid <= issue_valid && is_mul;
            for (int i = 1; i < `MULT_STAGES; i++) begin
                mul_q[i].valid <= mul_q[i-1].valid;
            end
        end
    end

    assign cdb_out = mul_q[`MULT_STAGES-1].valid ? mul_q[`MULT_STAGES-1] : alu_q;

    assign cdb.valid    = cdb_out.valid;
    assign cdb.dest_prn = cdb_out.dest_prn;
    assign cdb.robn     = cdb_out.robn;
    assign cdb.value    = cdb_out.value;

endmodule

/* rs.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rs (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      insert_en,
    input  ooo_issue_pkg::rs_entry_t  insert_entry,
    cdb_bus.sink                      cdb,
    input  logic                      alu_avail,
    output logic                      issue_valid,
    output ooo_issue_pkg::rs_entry_t  issue_entry,
    output logic                      full
);

    import ooo_issue_pkg::*;

    localparam int IDX_W = $clog2(`RS_SZ);

    rs_entry_t        entries [`RS_SZ];
    logic [IDX_W-1:0] issue_idx;
    logic [IDX_W-1:0] free_idx;
    logic             has_free;

    // descending scan so the lowest index wins
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        has_free    = 1'b0;
        free_idx    = '0;
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].op1_ready && entries[i].op2_ready &&
                    (entries[i].op == OP_MUL || alu_avail)) begin
                issue_valid = 1'b1;
                issue_idx   = IDX_W'(i);
            end
            if (!entries[i].valid) begin
                has_free = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    assign issue_entry = entries[issue_idx];
    assign full        = !has_free;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // wakeup on tag match
            for (int i = 0; i < `RS_SZ; i++) begin
                if (entries[i].valid && cdb.valid) begin
                    if (!entries[i].op1_ready && entries[i].op1.tag.prn == cdb.dest_prn) begin
                        entries[i].op1.value <= cdb.value;
                        entries[i].op1_ready <= 1'b1;
                    end
                    if (!entries[i].op2_ready && entries[i].op2.tag.prn == cdb.dest_prn) begin
                        entries[i].op2.value <= cdb.value;
                        entries[i].op2_ready <= 1'b1;
                    end
                end
            end
            if (issue_valid) begin
                entries[issue_idx].valid <= 1'b0;
            end
            if (insert_en) begin
                entries[free_idx] <= insert_entry;
            end
        end
    end

endmodule

/* prf.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module prf (
    input  logic              clock,
    input  logic              reset,
    input  logic [`PRN_W-1:0] read_prn1,
    input  logic [`PRN_W-1:0] read_prn2,
    output logic [`XLEN-1:0]  read_value1,
    output logic [`XLEN-1:0]  read_value2,
    output logic              read_ready1,
    output logic              read_ready2,
    input  logic              alloc_en,
    input  logic [`PRN_W-1:0] alloc_prn,
    cdb_bus.sink              cdb,
    commit_bus.sink           commit,
    output logic [`XLEN-1:0]  commit_value
);

    logic [`XLEN-1:0]        values [`PHYS_REG_SZ];
    logic [`PHYS_REG_SZ-1:0] ready;

    assign read_value1 = values[read_prn1];
    assign read_value2 = values[read_prn2];
    assign read_ready1 = ready[read_prn1];
    assign read_ready2 = ready[read_prn2];

    always_ff @(posedge clock) begin
        if (reset) begin
            // architectural state starts at zero
            for (int i = 0; i < `PHYS_REG_SZ; i++) begin
                values[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (alloc_en) begin
                ready[alloc_prn] <= 1'b0;
            end
            // p0 stays zero
            if (cdb.valid && (cdb.dest_prn != '0)) begin
                values[cdb.dest_prn] <= cdb.value;
                ready[cdb.dest_prn]  <= 1'b1;
            end
        end
    end

    // third read port for the commit output
    always_ff @(posedge clock) begin
        if (commit.valid) begin
            commit_value <= values[commit.dest_prn];
        end
    end

endmodule

/* rename_map.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rename_map (
    input  logic              clock,
    input  logic              reset,
    input  logic              rename_en,
    input  logic [`ARN_W-1:0] src1_arn,
    input  logic [`ARN_W-1:0] src2_arn,
    input  logic [`ARN_W-1:0] dest_arn,
    output logic [`PRN_W-1:0] src1_prn,
    output logic [`PRN_W-1:0] src2_prn,
    output logic [`PRN_W-1:0] dest_prn,
    output logic [`PRN_W-1:0] old_prn,
    output logic              free_empty,
    commit_bus.sink           commit
);

    localparam int FREE_SZ    = `PHYS_REG_SZ - `ARCH_REG_SZ;
    localparam int FREE_PTR_W = $clog2(FREE_SZ);

    logic [`PRN_W-1:0]      spec_map   [`ARCH_REG_SZ];
    logic [`PRN_W-1:0]      free_list  [FREE_SZ];
    logic [FREE_PTR_W-1:0]  head;
    logic [FREE_PTR_W-1:0]  tail;
    logic [`FREE_CNT_W-1:0] count;
    logic                   pop;
    logic                   push;

    // r0 is hardwired to p0
    assign pop  = rename_en && (dest_arn != '0);
    assign push = commit.valid && (commit.dest_arn != '0);

    assign src1_prn   = spec_map[src1_arn];
    assign src2_prn   = spec_map[src2_arn];
    assign dest_prn   = (dest_arn == '0) ? '0 : free_list[head];
    assign old_prn    = spec_map[dest_arn];
    assign free_empty = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                spec_map[i] <= `PRN_W'(i);
            end
            for (int i = 0; i < FREE_SZ; i++) begin
                free_list[i] <= `PRN_W'(i + `ARCH_REG_SZ);
            end
            head  <= '0;
            tail  <= '0;
            count <= `FREE_CNT_W'(FREE_SZ);
        end else begin
            if (pop) begin
                spec_map[dest_arn] <= free_list[head];
                head               <= head + 1'b1;
            end
            if (push) begin
                free_list[tail] <= commit.old_prn;
                tail            <= tail + 1'b1;
            end
            count <= count + `FREE_CNT_W'(push) - `FREE_CNT_W'(pop);
        end
    end

endmodule

/* ooo_bus_if.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

// one result per cycle from the function units
interface cdb_bus;
    logic               valid;
    logic [`PRN_W-1:0]  dest_prn;
    logic [`ROBN_W-1:0] robn;
    logic [`XLEN-1:0]   value;

    modport source(output valid, dest_prn, robn, value);
    modport sink(input valid, dest_prn, robn, value);
endinterface

// in-order retirement from the rob head
interface commit_bus;
    logic              valid;
    logic [`ARN_W-1:0] dest_arn;
    logic [`PRN_W-1:0] dest_prn;
    logic [`PRN_W-1:0] old_prn;

    modport source(output valid, dest_arn, dest_prn, old_prn);
    modport sink(input valid, dest_arn, dest_prn, old_prn);
endinterface

/* ooo_commit_pkg.sv */
`include "ooo_defines.svh"

package ooo_commit_pkg;

    typedef struct packed {
        logic               valid;
        logic [`PRN_W-1:0]  dest_prn;
        logic [`ROBN_W-1:0] robn;
        logic [`XLEN-1:0]   value;
    } cdb_t;

    // old_prn goes back to the free list at commit
    typedef struct packed {
        logic [`ARN_W-1:0] dest_arn;
        logic [`PRN_W-1:0] dest_prn;
        logic [`PRN_W-1:0] old_prn;
        logic              done;
    } rob_entry_t;

endpackage

/* ooo_issue_pkg.sv */
`include "ooo_defines.svh"

package ooo_issue_pkg;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LI,
        OP_MUL
    } alu_op_e;

    typedef struct packed {
        logic [`XLEN-`PRN_W-1:0] pad;
        logic [`PRN_W-1:0]       prn;
    } operand_tag_t;

    // value once ready, producer tag while waiting
    typedef union packed {
        logic [`XLEN-1:0] value;
        operand_tag_t     tag;
    } operand_u;

    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic               op1_ready;
        operand_u           op1;
        logic               op2_ready;
        operand_u           op2;
        logic [`PRN_W-1:0]  dest_prn;
        logic [`ROBN_W-1:0] robn;
    } rs_entry_t;

endpackage

/* ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath and structure sizes
`define XLEN         16
`define ARCH_REG_SZ  8
`define PHYS_REG_SZ  24
`define ROB_SZ       8
`define RS_SZ        4
`define MULT_STAGES  3

// index widths
`define ARN_W        3
`define PRN_W        5
`define ROBN_W       3
`define FREE_CNT_W   5

`endif
